// ==== spart_drv_defines.svh ====
`ifndef SPART_DRV_DEFINES_SVH
`define SPART_DRV_DEFINES_SVH

// spart data bus and peek data width
`define DATA_W 8

// peek port address widths
`define REG_ADDR_W 5
`define MEM_ADDR_W 5

// register index wraps modulo 256
`define IDX_W 8

// dump section ends at this index
`define DUMP_LIMIT 10

////////////////////////////////
// ascii codes
////////////////////////////////
`define ASCII_ZERO  8'h30
`define ASCII_SPACE 8'h20
`define ASCII_CR    8'h0d
`define ASCII_DEC   8'h31
`define ASCII_INC   8'h32

////////////////////////////////
// baud divisor bytes per br_cfg
////////////////////////////////
// 4800 baud
`define BAUD_LO_0 8'hc0
`define BAUD_HI_0 8'h12
// 9600 baud
`define BAUD_LO_1 8'h80
`define BAUD_HI_1 8'h25
// 19200 baud
`define BAUD_LO_2 8'h00
`define BAUD_HI_2 8'h4b
// 38400 baud
`define BAUD_LO_3 8'h00
`define BAUD_HI_3 8'h96

`endif

// ==== spart_drv_pkg.sv ====
package spart_drv_pkg;

	// sequencer states
	typedef enum logic [3:0] {
		baud_lo,
		baud_hi,
		rx_wait,
		send_idx,
		send_reg,
		send_sep,
		send_mem,
		send_echo
	} seq_state_t;

	// spart register select
	typedef enum logic [1:0] {
		io_data   = 2'd0,
		io_status = 2'd1,
		io_div_lo = 2'd2,
		io_div_hi = 2'd3
	} ioaddr_t;

	// decoded receive byte
	typedef enum logic [1:0] {
		cmd_none,
		cmd_dump,
		cmd_dec,
		cmd_inc
	} cmd_t;

endpackage

// ==== dump_ifs.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

////////////////////////////////
// register dump cursor link
////////////////////////////////
interface reg_cursor_if;
	// one-cycle step pulses from the sequencer
	logic inc;
	logic dec;
	// index reached the dump limit
	logic done;
	// index as ascii digit
	logic [`DATA_W-1:0] idx_char;
	// register value as ascii digit
	logic [`DATA_W-1:0] val_char;

	modport seq (output inc, dec, input done, idx_char, val_char);
	modport cursor (input inc, dec, output done, idx_char, val_char);
endinterface

////////////////////////////////
// memory dump cursor link
////////////////////////////////
interface mem_cursor_if;
	// advance and rewind pulses
	logic inc;
	logic clear;
	// memory index reached the dump limit
	logic done;
	// memory value as ascii digit
	logic [`DATA_W-1:0] val_char;

	modport seq (output inc, clear, input done, val_char);
	modport cursor (input inc, clear, output done, val_char);
endinterface

// ==== reg_dump_cursor.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

module reg_dump_cursor (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`DATA_W-1:0]     reg_data,
	output logic [`REG_ADDR_W-1:0] reg_addr,
	reg_cursor_if.cursor           cur
);

	// current register index
	// a dump starts from wherever this sits
	logic [`IDX_W-1:0] idx;

	// step up or down, wraps modulo 256
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
		end else if (cur.inc) begin
			idx <= idx + `IDX_W'(1);
		end else if (cur.dec) begin
			idx <= idx - `IDX_W'(1);
		end
	end

	// peek address from the low index bits
	assign reg_addr = idx[`REG_ADDR_W-1:0];

	// register part ends at the limit
	assign cur.done = (idx >= `IDX_W'(`DUMP_LIMIT));

	// ascii formatting, plain add so values past 9 just run on
	assign cur.idx_char = idx[`DATA_W-1:0] + `ASCII_ZERO;
	assign cur.val_char = reg_data + `ASCII_ZERO;

endmodule

// ==== mem_dump_cursor.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

module mem_dump_cursor (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`DATA_W-1:0]     mem_data,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	mem_cursor_if.cursor           cur
);

	// memory dump position
	logic [`MEM_ADDR_W-1:0] idx;

	// clear wins over inc
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
		end else if (cur.clear) begin
			idx <= '0;
		end else if (cur.inc) begin
			idx <= idx + `MEM_ADDR_W'(1);
		end
	end

	assign mem_addr = idx;

	// memory part finished
	assign cur.done = (idx >= `MEM_ADDR_W'(`DUMP_LIMIT));

	// value as ascii digit
	assign cur.val_char = mem_data + `ASCII_ZERO;

endmodule

// ==== spart_sequencer.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

module spart_sequencer import spart_drv_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [1:0]         br_cfg,
	input  logic               rda,
	input  logic               tbr,
	input  logic [`DATA_W-1:0] rx_byte,
	output logic               iocs,
	output logic               iorw,
	output ioaddr_t            ioaddr,
	output logic [`DATA_W-1:0] tx_byte,
	output logic               bus_oe,
	reg_cursor_if.seq          rc,
	mem_cursor_if.seq          mc
);

	seq_state_t state, nxt_state;
	cmd_t cmd;

	// divisor bytes for the selected rate
	logic [`DATA_W-1:0] div_lo, div_hi;

	// high once the memory index has left zero
	logic mem_started;

	////////////////////////////////
	// state and memory phase flops
	////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= baud_lo;
		end else begin
			state <= nxt_state;
		end
	end

	// tracks the memory cursor index being nonzero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_started <= 1'b0;
		end else if (mc.clear) begin
			mem_started <= 1'b0;
		end else if (mc.inc) begin
			mem_started <= 1'b1;
		end
	end

	// baud table lookup
	always_comb begin
		case (br_cfg)
			2'd0: begin
				div_lo = `BAUD_LO_0;
				div_hi = `BAUD_HI_0;
			end
			2'd1: begin
				div_lo = `BAUD_LO_1;
				div_hi = `BAUD_HI_1;
			end
			2'd2: begin
				div_lo = `BAUD_LO_2;
				div_hi = `BAUD_HI_2;
			end
			default: begin
				div_lo = `BAUD_LO_3;
				div_hi = `BAUD_HI_3;
			end
		endcase
	end

	// receive byte to command
	always_comb begin
		case (rx_byte)
			`ASCII_CR:  cmd = cmd_dump;
			`ASCII_DEC: cmd = cmd_dec;
			`ASCII_INC: cmd = cmd_inc;
			default:    cmd = cmd_none;
		endcase
	end

	////////////////////////////////
	// next state and bus control
	////////////////////////////////
	always_comb begin
		// idle bus, no pulses
		nxt_state = state;
		iocs      = 1'b0;
		iorw      = 1'b1;
		ioaddr    = io_data;
		tx_byte   = `ASCII_SPACE;
		bus_oe    = 1'b0;
		rc.inc    = 1'b0;
		rc.dec    = 1'b0;
		mc.inc    = 1'b0;
		mc.clear  = 1'b0;

		case (state)
			// divisor writes keep iorw high
			baud_lo: begin
				iocs      = 1'b1;
				ioaddr    = io_div_lo;
				tx_byte   = div_lo;
				bus_oe    = 1'b1;
				nxt_state = baud_hi;
			end
			baud_hi: begin
				iocs      = 1'b1;
				ioaddr    = io_div_hi;
				tx_byte   = div_hi;
				bus_oe    = 1'b1;
				nxt_state = rx_wait;
			end
			// read the byte in the cycle rda is seen
			rx_wait: begin
				if (rda) begin
					iocs = 1'b1;
					case (cmd)
						cmd_dump: nxt_state = send_idx;
						cmd_dec: begin
							rc.dec    = 1'b1;
							nxt_state = send_echo;
						end
						cmd_inc: begin
							rc.inc    = 1'b1;
							nxt_state = send_echo;
						end
						// unknown byte, dropped
						default: nxt_state = rx_wait;
					endcase
				end
			end
			// index digit, or skip to memory past the limit
			send_idx: begin
				if (rc.done) begin
					nxt_state = send_mem;
				end else if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					tx_byte   = rc.idx_char;
					bus_oe    = 1'b1;
					nxt_state = send_reg;
				end
			end
			// register digit, step index
			send_reg: begin
				if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					tx_byte   = rc.val_char;
					bus_oe    = 1'b1;
					rc.inc    = 1'b1;
					nxt_state = send_sep;
				end
			end
			// space, back to whichever part is running
			send_sep: begin
				if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					bus_oe    = 1'b1;
					nxt_state = mem_started ? send_mem : send_idx;
				end
			end
			// memory digit until done, then rewind
			send_mem: begin
				if (mc.done) begin
					mc.clear  = 1'b1;
					nxt_state = rx_wait;
				end else if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					tx_byte   = mc.val_char;
					bus_oe    = 1'b1;
					mc.inc    = 1'b1;
					nxt_state = send_sep;
				end
			end
			// updated index after '1' or '2'
			send_echo: begin
				if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					tx_byte   = rc.idx_char;
					bus_oe    = 1'b1;
					nxt_state = rx_wait;
				end
			end
			default: nxt_state = baud_lo;
		endcase
	end

endmodule

// ==== spart_driver.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

module spart_driver import spart_drv_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [1:0]             br_cfg,
	output logic                   iocs,
	output logic                   iorw,
	output ioaddr_t                ioaddr,
	inout  wire  [`DATA_W-1:0]     databus,
	input  logic                   rda,
	input  logic                   tbr,
	output logic [`REG_ADDR_W-1:0] reg_addr,
	input  logic [`DATA_W-1:0]     reg_data,
	output logic [`MEM_ADDR_W-1:0] mem_addr,
	input  logic [`DATA_W-1:0]     mem_data
);

	logic [`DATA_W-1:0] tx_byte;
	logic [`DATA_W-1:0] rx_byte;
	logic               bus_oe;

	// cursor links
	reg_cursor_if rc_if ();
	mem_cursor_if mc_if ();

	reg_dump_cursor u_reg_cur (
		.clk      (clk),
		.rst      (rst),
		.reg_data (reg_data),
		.reg_addr (reg_addr),
		.cur      (rc_if)
	);

	mem_dump_cursor u_mem_cur (
		.clk      (clk),
		.rst      (rst),
		.mem_data (mem_data),
		.mem_addr (mem_addr),
		.cur      (mc_if)
	);

	spart_sequencer u_seq (
		.clk     (clk),
		.rst     (rst),
		.br_cfg  (br_cfg),
		.rda     (rda),
		.tbr     (tbr),
		.rx_byte (rx_byte),
		.iocs    (iocs),
		.iorw    (iorw),
		.ioaddr  (ioaddr),
		.tx_byte (tx_byte),
		.bus_oe  (bus_oe),
		.rc      (rc_if),
		.mc      (mc_if)
	);

	// tristate bus, drive only when sending
	assign databus = bus_oe ? tx_byte : 'z;
	// spart byte seen straight off the bus
	assign rx_byte = databus;

endmodule

// ==== spart_driver_props.sv ====
`timescale 1ns/100ps

module spart_driver_props import spart_drv_pkg::*; (
	input logic    clk,
	input logic    rst,
	input logic    iocs,
	input logic    iorw,
	input ioaddr_t ioaddr,
	input logic    rda,
	input logic    tbr,
	input logic    bus_oe
);

	logic tx_strobe;
	logic rx_read;

	// data register selected, write or read
	assign tx_strobe = iocs && !iorw && (ioaddr == io_data);
	assign rx_read   = iocs && iorw && (ioaddr == io_data);

	// transmit only into an empty buffer
	tx_needs_tbr: assert property (@(posedge clk) disable iff (rst) tx_strobe |-> tbr)
		else $error("transmit strobe while tbr low");

	// read only when a byte is waiting
	rx_needs_rda: assert property (@(posedge clk) disable iff (rst) rx_read |-> rda)
		else $error("receive read while rda low");

	// data writes always target the data register
	write_is_data: assert property (@(posedge clk) disable iff (rst)
			!iorw |-> (iocs && ioaddr == io_data))
		else $error("iorw low outside a data write");

	// bus released while the spart drives it
	rx_bus_free: assert property (@(posedge clk) disable iff (rst) rx_read |-> !bus_oe)
		else $error("driver holds the bus during a receive read");

endmodule

// ==== tb_spart_driver.sv ====
`timescale 1ns/100ps

`include "spart_drv_defines.svh"

module tb_spart_driver import spart_drv_pkg::*; #(
	parameter int seed = 32715
);

	// cycle limits for each kind of wait
	localparam int rx_timeout    = 200;
	localparam int drain_timeout = 2000;

	logic                   clk;
	logic                   rst;
	logic [1:0]             br_cfg;
	logic                   iocs;
	logic                   iorw;
	ioaddr_t                ioaddr;
	wire  [`DATA_W-1:0]     databus;
	logic                   rda;
	logic                   tbr;
	logic [`REG_ADDR_W-1:0] reg_addr;
	logic [`DATA_W-1:0]     reg_data;
	logic [`MEM_ADDR_W-1:0] mem_addr;
	logic [`DATA_W-1:0]     mem_data;

	// spart side of the bus
	logic [`DATA_W-1:0] rx_data;
	logic               spart_drive;
	int                 tbr_low_left;

	// core model contents
	logic [`DATA_W-1:0] core_regs [32];
	logic [`DATA_W-1:0] core_mems [32];

	// scoreboard
	logic [`DATA_W-1:0] exp_q [$];
	logic [`IDX_W-1:0]  model_idx;
	int                 reads_seen;
	int                 byte_errors;
	int                 addr_errors;
	int                 level_errors;
	int                 strobe_errors;
	int                 timeout_errors;

	spart_driver uut (
		.clk      (clk),
		.rst      (rst),
		.br_cfg   (br_cfg),
		.iocs     (iocs),
		.iorw     (iorw),
		.ioaddr   (ioaddr),
		.databus  (databus),
		.rda      (rda),
		.tbr      (tbr),
		.reg_addr (reg_addr),
		.reg_data (reg_data),
		.mem_addr (mem_addr),
		.mem_data (mem_data)
	);

	bind spart_driver spart_driver_props u_props (
		.clk    (clk),
		.rst    (rst),
		.iocs   (iocs),
		.iorw   (iorw),
		.ioaddr (ioaddr),
		.rda    (rda),
		.tbr    (tbr),
		.bus_oe (bus_oe)
	);

	always #2 clk = ~clk;

	// peek ports answer in the same cycle
	assign reg_data = core_regs[reg_addr];
	assign mem_data = core_mems[mem_addr];

	// spart puts the byte on the bus only for a receive read
	assign spart_drive = rda && iocs && iorw && (ioaddr == io_data);
	assign databus = spart_drive ? rx_data : 'z;

	////////////////////////////////
	// compare tasks
	////////////////////////////////
	task automatic check_byte(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			byte_errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ioaddr(input ioaddr_t got, input ioaddr_t exp, input string what);
		if (got !== exp) begin
			addr_errors++;
			$display("FAIL %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	// single control strobe level
	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			level_errors++;
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// divisor table, high byte on top
	function automatic logic [2*`DATA_W-1:0] divisor_for(input logic [1:0] cfg);
		case (cfg)
			2'd0: return {`BAUD_HI_0, `BAUD_LO_0};
			2'd1: return {`BAUD_HI_1, `BAUD_LO_1};
			2'd2: return {`BAUD_HI_2, `BAUD_LO_2};
			default: return {`BAUD_HI_3, `BAUD_LO_3};
		endcase
	endfunction

	////////////////////////////////
	// bus monitor
	////////////////////////////////
	// sampled mid-cycle, well clear of both drive and clock edge
	always @(negedge clk) begin
		if (!rst) begin
			if (iocs && !iorw && ioaddr == io_data) begin
				if (exp_q.size() == 0) begin
					strobe_errors++;
					$display("transmit strobe at %0t with byte %h when none was due", $time,
						databus);
				end else begin
					check_byte(databus, exp_q.pop_front(), "transmit char");
				end
			end
			if (iocs && iorw && ioaddr == io_data && rda) begin
				reads_seen++;
			end
		end
	end

	// random tbr low stretches of one to four cycles
	always @(posedge clk) begin
		#1;
		if (tbr_low_left != 0) begin
			tbr = 1'b0;
			tbr_low_left--;
		end else if ($urandom_range(0, 3) == 0) begin
			tbr = 1'b0;
			tbr_low_left = $urandom_range(0, 3);
		end else begin
			tbr = 1'b1;
		end
	end

	////////////////////////////////
	// stimulus and model
	////////////////////////////////
	task automatic apply_reset(input logic [1:0] cfg);
		@(posedge clk);
		#1;
		rst = 1'b1;
		rda = 1'b0;
		br_cfg = cfg;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		model_idx = '0;
		exp_q.delete();
	endtask

	// divisor bytes in the two cycles after release
	task automatic check_baud(input logic [1:0] cfg);
		logic [2*`DATA_W-1:0] div;
		div = divisor_for(cfg);
		@(negedge clk);
		check_level(iocs, 1'b1, "divisor low iocs");
		check_ioaddr(ioaddr, io_div_lo, "divisor low address");
		check_byte(databus, div[`DATA_W-1:0], "divisor low byte");
		@(negedge clk);
		check_level(iocs, 1'b1, "divisor high iocs");
		check_ioaddr(ioaddr, io_div_hi, "divisor high address");
		check_byte(databus, div[2*`DATA_W-1:`DATA_W], "divisor high byte");
	endtask

	// mostly commands, some junk
	function automatic logic [`DATA_W-1:0] pick_command();
		int r;
		logic [`DATA_W-1:0] other;
		r = $urandom_range(0, 99);
		if (r < 35) return `ASCII_INC;
		if (r < 60) return `ASCII_DEC;
		if (r < 78) return `ASCII_CR;
		other = `DATA_W'($urandom_range(0, 255));
		if (other == `ASCII_CR || other == `ASCII_DEC || other == `ASCII_INC) begin
			other = 8'h7e;
		end
		return other;
	endfunction

	// expected character stream for one received byte
	task automatic expect_for(input logic [`DATA_W-1:0] b);
		int m;
		case (b)
			`ASCII_DEC: begin
				model_idx = model_idx - `IDX_W'(1);
				exp_q.push_back(model_idx[`DATA_W-1:0] + `ASCII_ZERO);
			end
			`ASCII_INC: begin
				model_idx = model_idx + `IDX_W'(1);
				exp_q.push_back(model_idx[`DATA_W-1:0] + `ASCII_ZERO);
			end
			`ASCII_CR: begin
				// register triples up to the limit, index left at the limit
				while (model_idx < `IDX_W'(`DUMP_LIMIT)) begin
					exp_q.push_back(model_idx[`DATA_W-1:0] + `ASCII_ZERO);
					exp_q.push_back(core_regs[model_idx[`REG_ADDR_W-1:0]] + `ASCII_ZERO);
					exp_q.push_back(`ASCII_SPACE);
					model_idx = model_idx + `IDX_W'(1);
				end
				// memory always from address zero
				for (m = 0; m < `DUMP_LIMIT; m++) begin
					exp_q.push_back(core_mems[m] + `ASCII_ZERO);
					exp_q.push_back(`ASCII_SPACE);
				end
			end
			// junk bytes expect nothing
			default: ;
		endcase
	endtask

	// offer one byte, wait for the read, then for its characters
	task automatic run_command(input logic [`DATA_W-1:0] b);
		int n;
		int reads_before;
		// one quiet cycle in rx_wait, nothing due yet
		@(posedge clk);
		@(negedge clk);
		check_level(iocs, 1'b0, "iocs while waiting");
		expect_for(b);
		@(posedge clk);
		#1;
		rx_data = b;
		rda = 1'b1;
		reads_before = reads_seen;
		n = 0;
		while (reads_seen == reads_before && n < rx_timeout) begin
			@(posedge clk);
			n++;
		end
		#1;
		rda = 1'b0;
		if (reads_seen == reads_before) begin
			timeout_errors++;
			$display("timeout: the driver never read command byte %h", b);
		end else begin
			n = 0;
			while (exp_q.size() != 0 && n < drain_timeout) begin
				@(posedge clk);
				n++;
			end
			if (exp_q.size() != 0) begin
				timeout_errors++;
				$display("timeout: %0d characters for byte %h never came", exp_q.size(), b);
			end
		end
	endtask

	initial begin
		int round;
		int n;
		logic [1:0] cfg;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		br_cfg = 2'd0;
		rda = 1'b0;
		tbr = 1'b1;
		rx_data = '0;
		tbr_low_left = 0;
		model_idx = '0;
		reads_seen = 0;
		byte_errors = 0;
		addr_errors = 0;
		level_errors = 0;
		strobe_errors = 0;
		timeout_errors = 0;
		for (n = 0; n < 32; n++) begin
			core_regs[n] = `DATA_W'($urandom_range(0, 255));
			core_mems[n] = `DATA_W'($urandom_range(0, 255));
		end
		// new baud setting per reset, then a run of commands
		for (round = 0; round < 4 && timeout_errors == 0; round++) begin
			cfg = 2'($urandom_range(0, 3));
			apply_reset(cfg);
			check_baud(cfg);
			for (n = 0; n < 60 && timeout_errors == 0; n++) begin
				run_command(pick_command());
			end
		end
		// idle tail catches stray strobes
		repeat (20) @(posedge clk);
		$display("errors: %0d byte, %0d ioaddr, %0d level, %0d stray strobe, %0d timeout",
			byte_errors, addr_errors, level_errors, strobe_errors, timeout_errors);
		if (byte_errors + addr_errors + level_errors + strobe_errors + timeout_errors == 0)
			begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
spart_drv_pkg.sv
dump_ifs.sv
reg_dump_cursor.sv
mem_dump_cursor.sv
spart_sequencer.sv
spart_driver.sv
spart_driver_props.sv
tb_spart_driver.sv

// ==== Makefile ====
# verilator build and run of the spart driver testbench

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_spart_driver
SEED      ?= 32715
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Gseed=$(SEED) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
